// File: src/edgeCiPkg.sv
package edgeCiPkg;

    // --------------------------------------------------
    // Port and data widths
    // --------------------------------------------------
    parameter int pixelWidth    = 8;
    parameter int ciDataWidth   = 32;
    parameter int ciNumberWidth = 8;

    // --------------------------------------------------
    // Edge unit opcodes, carried in valueB[7:0]
    // --------------------------------------------------
    // Pixels 0 to 3 from valueA, byte 0 first.
    parameter logic [7:0] opLoadLow         = 8'd0;
    // Pixels 4 to 7 from valueA, pixel 8 and threshold from valueB, then compute.
    parameter logic [7:0] opLoadHighCompute = 8'd1;

    // Edge output levels.
    parameter logic [pixelWidth-1:0] edgeOn  = 8'd255;
    parameter logic [pixelWidth-1:0] edgeOff = 8'd0;

    // --------------------------------------------------
    // Control word in valueB, decoded per opcode
    // --------------------------------------------------
    typedef union packed {
        struct packed {
            logic [23:0] reserved;
            logic [7:0]  opcode;
        } loadLow;
        struct packed {
            logic [7:0]            reserved;
            logic [pixelWidth-1:0] threshold;
            logic [pixelWidth-1:0] pixel8;
            logic [7:0]            opcode;
        } loadHighCompute;
    } ciControlWord;

endpackage

// File: src/sobelKernel.sv
module sobelKernel (
    input  logic [edgeCiPkg::pixelWidth-1:0] pixel0,
    input  logic [edgeCiPkg::pixelWidth-1:0] pixel1,
    input  logic [edgeCiPkg::pixelWidth-1:0] pixel2,
    input  logic [edgeCiPkg::pixelWidth-1:0] pixel3,
    input  logic [edgeCiPkg::pixelWidth-1:0] pixel4,
    input  logic [edgeCiPkg::pixelWidth-1:0] pixel5,
    input  logic [edgeCiPkg::pixelWidth-1:0] pixel6,
    input  logic [edgeCiPkg::pixelWidth-1:0] pixel7,
    input  logic [edgeCiPkg::pixelWidth-1:0] pixel8,
    input  logic [edgeCiPkg::pixelWidth-1:0] threshold,
    output logic [edgeCiPkg::pixelWidth-1:0] edgeValue
);

    import edgeCiPkg::*;

    // Largest gradient is 4 * 255 = 1020, so 11 signed bits hold it.
    localparam int gradWidth = 11;

    // Window layout, row by row.
    //   p0 p1 p2
    //   p3 p4 p5
    //   p6 p7 p8
    // The centre pixel has zero weight in both kernels.

    logic signed [gradWidth-1:0] gxPos;
    logic signed [gradWidth-1:0] gxNeg;
    logic signed [gradWidth-1:0] gyPos;
    logic signed [gradWidth-1:0] gyNeg;
    logic signed [gradWidth-1:0] gx;
    logic signed [gradWidth-1:0] gy;
    logic        [gradWidth-1:0] absGx;
    logic        [gradWidth-1:0] absGy;
    logic        [gradWidth-1:0] magnitude;

    function automatic logic signed [gradWidth-1:0] widen(
        input logic [pixelWidth-1:0] pixel
    );
        return signed'({{(gradWidth - pixelWidth){1'b0}}, pixel});
    endfunction

    function automatic logic [gradWidth-1:0] absValue(
        input logic signed [gradWidth-1:0] value
    );
        logic signed [gradWidth-1:0] negated;
        negated = -value;
        return value[gradWidth-1] ? negated : value;
    endfunction

    // --------------------------------------------------
    // Gradients
    // --------------------------------------------------
    always_comb begin
        // Right column minus left column.
        gxPos = widen(pixel2) + (widen(pixel5) <<< 1) + widen(pixel8);
        gxNeg = widen(pixel0) + (widen(pixel3) <<< 1) + widen(pixel6);
        gx    = gxPos - gxNeg;

        // Bottom row minus top row.
        gyPos = widen(pixel6) + (widen(pixel7) <<< 1) + widen(pixel8);
        gyNeg = widen(pixel0) + (widen(pixel1) <<< 1) + widen(pixel2);
        gy    = gyPos - gyNeg;
    end

    // --------------------------------------------------
    // Magnitude and threshold
    // --------------------------------------------------
    always_comb begin
        absGx = absValue(gx);
        absGy = absValue(gy);
        // At most 2040, no overflow in 11 bits.
        magnitude = absGx + absGy;
    end

    always_comb begin
        if (magnitude > {{(gradWidth - pixelWidth){1'b0}}, threshold}) begin
            edgeValue = edgeOn;
        end else begin
            edgeValue = edgeOff;
        end
    end

endmodule

// File: src/edgeDetectCi.sv
module edgeDetectCi #(
    parameter logic [edgeCiPkg::ciNumberWidth-1:0] customInstructionId = '0
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 start,
    input  logic [edgeCiPkg::ciNumberWidth-1:0]  ciN,
    input  logic [edgeCiPkg::ciDataWidth-1:0]    valueA,
    input  logic [edgeCiPkg::ciDataWidth-1:0]    valueB,
    output logic                                 done,
    output logic [edgeCiPkg::ciDataWidth-1:0]    result
);

    import edgeCiPkg::*;

    localparam int windowSize    = 9;
    localparam int pixelsPerWord = ciDataWidth / pixelWidth;

    ciControlWord          control;
    logic                  addressed;
    logic                  isLoadLow;
    logic                  isCompute;
    logic                  pending;
    logic [pixelWidth-1:0] window [windowSize];
    logic [pixelWidth-1:0] threshold;
    logic [pixelWidth-1:0] edgeValue;

    // --------------------------------------------------
    // Instruction decode
    // --------------------------------------------------
    assign control   = ciControlWord'(valueB);
    assign addressed = start && (ciN == customInstructionId);
    assign isLoadLow = (control.loadLow.opcode == opLoadLow);
    assign isCompute = (control.loadHighCompute.opcode == opLoadHighCompute);

    // Loads and unknown opcodes finish at once.
    // A compute waits for the window write, so done follows one cycle later.
    always_comb begin
        if (!addressed) begin
            done = 1'b0;
        end else if (isCompute) begin
            done = pending;
        end else begin
            done = 1'b1;
        end
    end

    always_comb begin
        if (done && isCompute) begin
            result = {{(ciDataWidth - pixelWidth){1'b0}}, edgeValue};
        end else begin
            result = '0;
        end
    end

    // --------------------------------------------------
    // Window, threshold and pending flag
    // --------------------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < windowSize; i++) begin
                window[i] <= '0;
            end
            threshold <= '0;
            pending   <= 1'b0;
        end else begin
            if (pending) begin
                // Done cycle ends here.
                pending <= 1'b0;
            end else if (addressed && isCompute) begin
                for (int i = 0; i < pixelsPerWord; i++) begin
                    window[pixelsPerWord + i] <= valueA[i*pixelWidth +: pixelWidth];
                end
                window[windowSize-1] <= control.loadHighCompute.pixel8;
                threshold            <= control.loadHighCompute.threshold;
                pending              <= 1'b1;
            end

            if (addressed && isLoadLow) begin
                for (int i = 0; i < pixelsPerWord; i++) begin
                    window[i] <= valueA[i*pixelWidth +: pixelWidth];
                end
            end
        end
    end

    // --------------------------------------------------
    // Gradient kernel
    // --------------------------------------------------
    sobelKernel sobelKernel_i (
        .pixel0    (window[0]),
        .pixel1    (window[1]),
        .pixel2    (window[2]),
        .pixel3    (window[3]),
        .pixel4    (window[4]),
        .pixel5    (window[5]),
        .pixel6    (window[6]),
        .pixel7    (window[7]),
        .pixel8    (window[8]),
        .threshold (threshold),
        .edgeValue (edgeValue)
    );

endmodule

// File: src/grayscaleCi.sv
module grayscaleCi #(
    parameter logic [edgeCiPkg::ciNumberWidth-1:0] customInstructionId = '0
) (
    input  logic                                 start,
    input  logic [edgeCiPkg::ciNumberWidth-1:0]  ciN,
    input  logic [edgeCiPkg::ciDataWidth-1:0]    valueA,
    output logic                                 done,
    output logic [edgeCiPkg::ciDataWidth-1:0]    result
);

    import edgeCiPkg::*;

    // Weights sum to 256, so the sum of three 8-bit products fits 16 bits.
    localparam int sumWidth = 16;
    localparam logic [sumWidth-1:0] redWeight   = 16'd77;
    localparam logic [sumWidth-1:0] greenWeight = 16'd150;
    localparam logic [sumWidth-1:0] blueWeight  = 16'd29;

    logic                  addressed;
    logic [pixelWidth-1:0] red;
    logic [pixelWidth-1:0] green;
    logic [pixelWidth-1:0] blue;
    logic [sumWidth-1:0]   lumaSum;
    logic [pixelWidth-1:0] luma;

    assign addressed = start && (ciN == customInstructionId);

    // Packed RGB888 in the low three bytes.
    assign red   = valueA[3*pixelWidth-1:2*pixelWidth];
    assign green = valueA[2*pixelWidth-1:pixelWidth];
    assign blue  = valueA[pixelWidth-1:0];

    always_comb begin
        lumaSum = redWeight * {{(sumWidth - pixelWidth){1'b0}}, red}
                + greenWeight * {{(sumWidth - pixelWidth){1'b0}}, green}
                + blueWeight * {{(sumWidth - pixelWidth){1'b0}}, blue};
        // Divide by 256.
        luma = lumaSum[sumWidth-1:sumWidth-pixelWidth];
    end

    // Single cycle unit.
    assign done = addressed;

    always_comb begin
        if (addressed) begin
            result = {{(ciDataWidth - pixelWidth){1'b0}}, luma};
        end else begin
            result = '0;
        end
    end

endmodule

// File: src/edgeCiTop.sv
module edgeCiTop #(
    parameter logic [edgeCiPkg::ciNumberWidth-1:0] edgeCiId = 8'd10,
    parameter logic [edgeCiPkg::ciNumberWidth-1:0] grayCiId = 8'd11
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 start,
    input  logic [edgeCiPkg::ciNumberWidth-1:0]  ciN,
    input  logic [edgeCiPkg::ciDataWidth-1:0]    valueA,
    input  logic [edgeCiPkg::ciDataWidth-1:0]    valueB,
    output logic                                 done,
    output logic [edgeCiPkg::ciDataWidth-1:0]    result
);

    import edgeCiPkg::*;

    logic                   edgeDone;
    logic [ciDataWidth-1:0] edgeResult;
    logic                   grayDone;
    logic [ciDataWidth-1:0] grayResult;

    // --------------------------------------------------
    // Instruction units
    // --------------------------------------------------
    edgeDetectCi #(
        .customInstructionId (edgeCiId)
    ) edgeDetectCi_i (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .ciN    (ciN),
        .valueA (valueA),
        .valueB (valueB),
        .done   (edgeDone),
        .result (edgeResult)
    );

    grayscaleCi #(
        .customInstructionId (grayCiId)
    ) grayscaleCi_i (
        .start  (start),
        .ciN    (ciN),
        .valueA (valueA),
        .done   (grayDone),
        .result (grayResult)
    );

    // --------------------------------------------------
    // Output merge
    // --------------------------------------------------
    // Idle units drive zero, so OR is enough.
    assign done   = edgeDone | grayDone;
    assign result = edgeResult | grayResult;

endmodule

// File: verification/edgeCiTb_chk.sv
module edgeDetectCiChk (
    input logic                             clock,
    input logic                             reset,
    input logic                             done,
    input logic                             pending,
    input logic                             addressed,
    input logic                             isCompute,
    input logic [edgeCiPkg::ciDataWidth-1:0] result
);
    timeunit 1ns;
    timeprecision 100ps;

    // --------------------------------------------------
    // Done protocol
    // --------------------------------------------------
    // Loads and unknown opcodes give a single pulse.
    singleDone: assert property (@(posedge clock) disable iff (reset)
        (done && !pending) |=> !done)
        else $error("done stayed high without a pending compute");

    // Compute start gives done one cycle later.
    computeLatency: assert property (@(posedge clock) disable iff (reset)
        (addressed && isCompute && !pending) |=> done)
        else $error("compute done did not follow one cycle after start");

    idleResultZero: assert property (@(posedge clock) disable iff (reset)
        !done |-> (result == '0))
        else $error("result nonzero while done is low");

endmodule

bind edgeDetectCi edgeDetectCiChk edgeDetectCiChk_i (
    .clock     (clock),
    .reset     (reset),
    .done      (done),
    .pending   (pending),
    .addressed (addressed),
    .isCompute (isCompute),
    .result    (result)
);

// File: verification/edgeCiTb.sv
module edgeCiTb;
    timeunit 1ns;
    timeprecision 100ps;

    import edgeCiPkg::*;

    localparam logic [ciNumberWidth-1:0] edgeId   = 8'd10;
    localparam logic [ciNumberWidth-1:0] grayId   = 8'd11;
    localparam logic [ciNumberWidth-1:0] unusedId = 8'd42;
    localparam logic [7:0] opUnknown   = 8'd2;
    localparam int         doneTimeout = 16;
    localparam int         runTimeout  = 5000;
    // Taps for x^32 + x^22 + x^2 + x + 1.
    localparam logic [31:0] lfsrMask = 32'h8020_0003;

    logic                     clock;
    logic                     reset;
    logic                     start;
    logic [ciNumberWidth-1:0] ciN;
    logic [ciDataWidth-1:0]   valueA;
    logic [ciDataWidth-1:0]   valueB;
    logic                     done;
    logic [ciDataWidth-1:0]   result;

    logic [31:0]              lfsrState = 32'h1199_eca5;
    logic [9*pixelWidth-1:0]  modelWindow;
    logic [pixelWidth-1:0]    modelThreshold;
    logic [ciDataWidth-1:0]   expectQueue [$];
    string                    labelQueue [$];
    int                       checkCount;
    int                       errorCount;
    int                       testErrors;

    edgeCiTop #(
        .edgeCiId (edgeId),
        .grayCiId (grayId)
    ) edgeCiTop_i (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .ciN    (ciN),
        .valueA (valueA),
        .valueB (valueB),
        .done   (done),
        .result (result)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    // --------------------------------------------------
    // Random source and reference models
    // --------------------------------------------------
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsrMask) : (state >> 1);
    endfunction

    // One LFSR step per bit taken.
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrStep(lfsrState);
            bits      = {bits[30:0], lfsrState[0]};
        end
        return bits;
    endfunction

    function automatic int sobelMagnitude(input logic [9*pixelWidth-1:0] pixels);
        int p [9];
        int gx;
        int gy;
        for (int i = 0; i < 9; i++) begin
            p[i] = int'(pixels[i*pixelWidth +: pixelWidth]);
        end
        gx = (p[2] + 2 * p[5] + p[8]) - (p[0] + 2 * p[3] + p[6]);
        gy = (p[6] + 2 * p[7] + p[8]) - (p[0] + 2 * p[1] + p[2]);
        if (gx < 0) gx = -gx;
        if (gy < 0) gy = -gy;
        return gx + gy;
    endfunction

    function automatic logic [ciDataWidth-1:0] sobelRef(
        input logic [9*pixelWidth-1:0] pixels,
        input logic [pixelWidth-1:0]   limit
    );
        return (sobelMagnitude(pixels) > int'(limit)) ? 32'd255 : 32'd0;
    endfunction

    function automatic logic [ciDataWidth-1:0] lumaRef(input logic [ciDataWidth-1:0] rgb);
        int r;
        int g;
        int b;
        r = int'(rgb[23:16]);
        g = int'(rgb[15:8]);
        b = int'(rgb[7:0]);
        return 32'((77 * r + 150 * g + 29 * b) / 256);
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic checkResult(
        input string                  label,
        input logic [ciDataWidth-1:0] actual,
        input logic [ciDataWidth-1:0] expected
    );
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at time %0t: result (%s) expected %0d, got %0d",
                     $time, label, expected, actual);
        end
    endtask

    task automatic checkLatency(input string label, input int actual, input int expected);
        checkCount++;
        if (actual != expected) begin
            errorCount++;
            $display("FAILED at time %0t: done latency (%s) expected %0d, got %0d",
                     $time, label, expected, actual);
        end
    endtask

    // Result check on every done pulse, in the order issued.
    initial begin
        forever begin
            @(negedge clock);
            if (!reset && done) begin
                if (expectQueue.size() == 0) begin
                    errorCount++;
                    $display("ERROR at time %0t: done came with no instruction waiting", $time);
                end else begin
                    checkResult(labelQueue.pop_front(), result, expectQueue.pop_front());
                end
            end
        end
    end

    // --------------------------------------------------
    // Instruction drivers
    // --------------------------------------------------
    task automatic issueInstruction(
        input string                    label,
        input logic [ciNumberWidth-1:0] number,
        input logic [ciDataWidth-1:0]   a,
        input logic [ciDataWidth-1:0]   b,
        input logic                     expectDone,
        input logic [ciDataWidth-1:0]   expected,
        input int                       expectedLatency
    );
        int   cycles;
        logic gotDone;
        cycles  = 0;
        gotDone = 1'b0;
        if (expectDone) begin
            expectQueue.push_back(expected);
            labelQueue.push_back(label);
        end
        @(posedge clock);
        start  <= 1'b1;
        ciN    <= number;
        valueA <= a;
        valueB <= b;
        // Done is sampled mid-cycle.
        while (!gotDone && cycles < doneTimeout) begin
            @(negedge clock);
            if (done) begin
                gotDone = 1'b1;
            end else begin
                cycles++;
            end
        end
        @(posedge clock);
        start  <= 1'b0;
        ciN    <= '0;
        valueA <= '0;
        valueB <= '0;
        if (expectDone && !gotDone) begin
            errorCount++;
            void'(expectQueue.pop_back());
            void'(labelQueue.pop_back());
            $display("ERROR: done never came for %s within %0d cycles", label, doneTimeout);
        end else if (expectDone) begin
            checkLatency(label, cycles, expectedLatency);
        end else if (gotDone) begin
            errorCount++;
            $display("ERROR: done came for %s, which no unit should answer", label);
        end
    endtask

    task automatic loadLowPixels(input string label);
        ciControlWord control;
        control                = '0;
        control.loadLow.opcode = opLoadLow;
        issueInstruction(label, edgeId, modelWindow[31:0], control, 1'b1, '0, 0);
    endtask

    task automatic computeEdge(input string label, input logic [ciDataWidth-1:0] expected);
        ciControlWord control;
        control                           = '0;
        control.loadHighCompute.opcode    = opLoadHighCompute;
        control.loadHighCompute.pixel8    = modelWindow[71:64];
        control.loadHighCompute.threshold = modelThreshold;
        issueInstruction(label, edgeId, modelWindow[63:32], control, 1'b1, expected, 1);
    endtask

    task automatic randomPixels(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            modelWindow[i*pixelWidth +: pixelWidth] = 8'(takeBits(8));
        end
    endtask

    task automatic finishTest(input string name);
        if (errorCount == testErrors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errorCount - testErrors);
        end
        testErrors = errorCount;
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        logic [ciDataWidth-1:0] rgb;
        reset          = 1'b1;
        start          = 1'b0;
        ciN            = '0;
        valueA         = '0;
        valueB         = '0;
        checkCount     = 0;
        errorCount     = 0;
        testErrors     = 0;
        modelWindow    = '0;
        modelThreshold = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // All-zero window, magnitude 0 is not above 0.
        computeEdge("compute after reset", 32'd0);
        finishTest("1 compute after reset");

        for (int n = 0; n < 50; n++) begin
            randomPixels(0, 8);
            modelThreshold = 8'(takeBits(8));
            loadLowPixels("random load low");
            computeEdge("random window", sobelRef(modelWindow, modelThreshold));
        end
        finishTest("2 random windows");

        // Vertical step, right column at 50, magnitude 200.
        modelWindow       = '0;
        modelWindow[23:16] = 8'd50;
        modelWindow[47:40] = 8'd50;
        modelWindow[71:64] = 8'd50;
        loadLowPixels("step load low");
        modelThreshold = 8'(sobelMagnitude(modelWindow));
        computeEdge("threshold equal to magnitude", 32'd0);
        modelThreshold = modelThreshold - 8'd1;
        computeEdge("threshold one below magnitude", 32'd255);
        finishTest("3 threshold corners");

        for (int n = 0; n < 50; n++) begin
            rgb = takeBits(32);
            issueInstruction("luma", grayId, rgb, '0, 1'b1, lumaRef(rgb), 0);
        end
        finishTest("4 random luma");

        randomPixels(0, 8);
        modelThreshold = 8'(takeBits(8));
        loadLowPixels("load low before unused number");
        issueInstruction("unused number", unusedId, ~modelWindow[31:0], '0, 1'b0, '0, 0);
        randomPixels(4, 8);
        computeEdge("compute after unused number", sobelRef(modelWindow, modelThreshold));
        finishTest("5 unused instruction number");

        issueInstruction("unknown opcode", edgeId, takeBits(32),
                         {24'(takeBits(24)), opUnknown}, 1'b1, '0, 0);
        computeEdge("compute after unknown opcode", sobelRef(modelWindow, modelThreshold));
        finishTest("6 unknown opcode");

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0 && expectQueue.size() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Whole run limit.
    initial begin
        for (int cycle = 0; cycle < runTimeout; cycle++) begin
            @(posedge clock);
        end
        $display("ERROR: run did not finish within %0d cycles", runTimeout);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: edgeCi.f
src/edgeCiPkg.sv
src/sobelKernel.sv
src/edgeDetectCi.sv
src/grayscaleCi.sv
src/edgeCiTop.sv
verification/edgeCiTb_chk.sv
verification/edgeCiTb.sv

// File: runSim.sh
#!/bin/sh
# Compile and run the edge coprocessor testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/100ps \
    --top-module edgeCiTb \
    -f edgeCi.f \
    -o simEdgeCi

# The log decides the outcome, so a stopped run is still examined.
./obj_dir/simEdgeCi > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
